//--- rtl/router_defs.svh
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// Number of router inputs sharing the output link.
`define ROUTER_PORTS 5

// Depth of each input flit buffer, a power of two.
`define FIFO_DEPTH 4

// Flit id that opens a packet and carries its hold window.
`define FLIT_HEAD 1

// Input port indices, also the rotation order.
`define PORT_L 0
`define PORT_N 1
`define PORT_E 2
`define PORT_W 3
`define PORT_S 4

`endif

//--- rtl/routerPkg.sv
`default_nettype none

`include "router_defs.svh"

package routerPkg;

  typedef logic [2:0] flitId_t;
  typedef logic [15:0] flitData_t;

  // Hold window in cycles, from the low data bits of a head flit.
  typedef logic [11:0] holdLen_t;

  typedef logic [2:0] portIdx_t;
  typedef logic [`ROUTER_PORTS-1:0] portMask_t;

  typedef struct packed {
    flitId_t id;
    flitData_t data;
  } flit_t;

  typedef enum logic [2:0] {
    stIdle = 3'd0,
    stL    = 3'd1,
    stN    = 3'd2,
    stE    = 3'd3,
    stW    = 3'd4,
    stS    = 3'd5
  } arbState_t;

endpackage

`default_nettype wire

//--- rtl/flitFifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "router_defs.svh"

module flitFifo (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            push,
  input  routerPkg::flit_t     pushFlit,
  input  wire logic            pop,
  output routerPkg::flit_t     headFlit,
  output logic                 notEmpty
);
  import routerPkg::*;

  localparam int PtrW = $clog2(`FIFO_DEPTH);
  localparam logic [PtrW:0] Full = (PtrW + 1)'(`FIFO_DEPTH);

  flit_t mem [`FIFO_DEPTH];
  logic [PtrW-1:0] rdPtr;
  logic [PtrW-1:0] wrPtr;
  logic [PtrW:0] count;
  logic doPush;
  logic doPop;

  // A push into a full buffer is lost.
  assign doPush = push && (count != Full);
  assign doPop = pop && notEmpty;

  assign notEmpty = (count != '0);
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doPush)
      mem[wrPtr] <= pushFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1;
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/holdTimer.sv
`timescale 1ns/100ps
`default_nettype none

`include "router_defs.svh"

module holdTimer (
  input  wire logic          clk,
  input  wire logic          rst,
  input  routerPkg::flitId_t headId,
  input  routerPkg::holdLen_t headLen,
  input  wire logic          run,
  output logic               timesUp
);
  import routerPkg::*;

  holdLen_t window;
  holdLen_t count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      window <= '0;
      count <= '0;
    end
    else
    begin
      // Each new packet at the buffer head brings its own window.
      if (headId == flitId_t'(`FLIT_HEAD))
        window <= headLen;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == window);

endmodule

`default_nettype wire

//--- rtl/portArbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "router_defs.svh"

module portArbiter (
  input  wire logic                               clk,
  input  wire logic                               rst,
  input  routerPkg::portMask_t                    notEmpty,
  input  routerPkg::flit_t [`ROUTER_PORTS-1:0]    headFlit,
  output routerPkg::portMask_t                    pop,
  output routerPkg::portIdx_t                     grantIdx
);
  import routerPkg::*;

  arbState_t state;
  arbState_t nextState;
  portIdx_t curPort;
  portMask_t run;
  portMask_t timesUp;

  function automatic arbState_t stateOf(int p);
    arbState_t s;
    case (p)
      `PORT_L: s = stL;
      `PORT_N: s = stN;
      `PORT_E: s = stE;
      `PORT_W: s = stW;
      `PORT_S: s = stS;
      default: s = stIdle;
    endcase
    return s;
  endfunction

  for (genvar i = 0; i < `ROUTER_PORTS; i++)
  begin : gTimer
    holdTimer uTimer (
      .clk     (clk),
      .rst     (rst),
      .headId  (headFlit[i].id),
      .headLen (holdLen_t'(headFlit[i].data)),
      .run     (run[i]),
      .timesUp (timesUp[i])
    );
  end

  always_comb
  begin
    case (state)
      stL: curPort = portIdx_t'(`PORT_L);
      stN: curPort = portIdx_t'(`PORT_N);
      stE: curPort = portIdx_t'(`PORT_E);
      stW: curPort = portIdx_t'(`PORT_W);
      stS: curPort = portIdx_t'(`PORT_S);
      default: curPort = portIdx_t'(`PORT_L);
    endcase
  end

  // The held port keeps the link until its buffer empties or its window
  // runs out. Then the other ports are tried in rotation after it.
  always_comb
  begin
    int cand;
    logic found;
    run = '0;
    nextState = stIdle;
    found = 1'b0;
    cand = 0;
    if (state == stIdle)
    begin
      for (int k = 0; k < `ROUTER_PORTS; k++)
      begin
        cand = `PORT_L + k;
        if (!found && notEmpty[cand])
        begin
          nextState = stateOf(cand);
          found = 1'b1;
        end
      end
    end
    else if (notEmpty[curPort] && !timesUp[curPort])
    begin
      run[curPort] = 1'b1;
      nextState = state;
    end
    else
    begin
      for (int k = 1; k < `ROUTER_PORTS; k++)
      begin
        cand = int'(curPort) + k;
        if (cand >= `ROUTER_PORTS)
          cand = cand - `ROUTER_PORTS;
        if (!found && notEmpty[cand])
        begin
          nextState = stateOf(cand);
          found = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    pop = '0;
    if (state != stIdle)
      pop[curPort] = notEmpty[curPort];
  end

  assign grantIdx = curPort;

endmodule

`default_nettype wire

//--- rtl/outputSwitch.sv
`timescale 1ns/100ps
`default_nettype none

`include "router_defs.svh"

module outputSwitch (
  input  wire logic                               clk,
  input  wire logic                               rst,
  input  routerPkg::portMask_t                    pop,
  input  routerPkg::portIdx_t                     grantIdx,
  input  routerPkg::flit_t [`ROUTER_PORTS-1:0]    headFlit,
  output logic                                    outValid,
  output routerPkg::flit_t                        outFlit,
  output routerPkg::portIdx_t                     outPort
);
  import routerPkg::*;

  flit_t selFlit;

  assign selFlit = headFlit[grantIdx];

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |pop;
  end

  // The flit and its source hold their value between deliveries.
  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outFlit <= selFlit;
      outPort <= grantIdx;
    end
  end

endmodule

`default_nettype wire

//--- rtl/routerOutputStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "router_defs.svh"

module routerOutputStage (
  input  wire logic                               clk,
  input  wire logic                               rst,
  input  routerPkg::portMask_t                    inPush,
  input  routerPkg::flit_t [`ROUTER_PORTS-1:0]    inFlit,
  output logic                                    outValid,
  output routerPkg::flit_t                        outFlit,
  output routerPkg::portIdx_t                     outPort
);
  import routerPkg::*;

  flit_t [`ROUTER_PORTS-1:0] headFlit;
  portMask_t notEmpty;
  portMask_t pop;
  portIdx_t grantIdx;

  for (genvar i = 0; i < `ROUTER_PORTS; i++)
  begin : gFifo
    flitFifo uFifo (
      .clk      (clk),
      .rst      (rst),
      .push     (inPush[i]),
      .pushFlit (inFlit[i]),
      .pop      (pop[i]),
      .headFlit (headFlit[i]),
      .notEmpty (notEmpty[i])
    );
  end

  portArbiter uArbiter (
    .clk      (clk),
    .rst      (rst),
    .notEmpty (notEmpty),
    .headFlit (headFlit),
    .pop      (pop),
    .grantIdx (grantIdx)
  );

  outputSwitch uSwitch (
    .clk      (clk),
    .rst      (rst),
    .pop      (pop),
    .grantIdx (grantIdx),
    .headFlit (headFlit),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

endmodule

`default_nettype wire

//--- verification/routerChecker.sv
`timescale 1ns/100ps
`default_nettype none

`include "router_defs.svh"

module routerChecker (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  routerPkg::portMask_t                 inPush,
  input  routerPkg::flit_t [`ROUTER_PORTS-1:0] inFlit,
  input  wire logic                            outValid,
  input  routerPkg::flit_t                     outFlit,
  input  routerPkg::portIdx_t                  outPort,
  input  wire logic [127:0]                    rowName,
  input  routerPkg::holdLen_t                  rowWindow,
  input  wire logic [7:0]                      rowMaxRun,
  input  wire logic                            rowStart,
  input  wire logic                            rowEnd,
  output int                                   errors,
  output int                                   flitCount,
  output logic                                 drained
);
  import routerPkg::*;

  flit_t expQ [`ROUTER_PORTS][$];
  int pending = 0;
  int lastPort = -1;
  int runLen = 0;
  int maxRun = 0;
  int rowErrors = 0;
  int rowFlits = 0;

  initial
  begin
    errors = 0;
    flitCount = 0;
  end

  assign drained = (pending == 0);

  // First port with queued flits after the last one in rotation order.
  // From idle the search starts at Local.
  function automatic int nextWaiting(int last);
    int p;
    int found;
    found = -1;
    for (int k = 0; k < `ROUTER_PORTS; k++)
    begin
      p = (last < 0) ? k : (last + 1 + k) % `ROUTER_PORTS;
      if (found < 0 && p != last && expQ[p].size() > 0)
        found = p;
    end
    return found;
  endfunction

  function automatic logic othersWaiting(int q);
    logic any;
    any = 1'b0;
    for (int p = 0; p < `ROUTER_PORTS; p++)
      if (p != q && expQ[p].size() > 0)
        any = 1'b1;
    return any;
  endfunction

  task automatic checkDelivery();
    int q;
    int want;
    flit_t expFlit;
    q = int'(outPort);
    flitCount++;
    rowFlits++;
    if (q >= `ROUTER_PORTS || expQ[q].size() == 0)
    begin
      $display("%s: a flit came out of port %0d with nothing queued there", rowName, q);
      errors++;
      rowErrors++;
    end
    else
    begin
      if (q != lastPort)
      begin
        want = nextWaiting(lastPort);
        if (want != q)
        begin
          $display("Error %s: next port expected %0d actual %0d", rowName, want, q);
          errors++;
          rowErrors++;
        end
        runLen = 1;
      end
      else
        runLen++;
      if (runLen > int'(rowWindow) + 1 && othersWaiting(q))
      begin
        $display("Error %s: run on port %0d expected at most %0d actual %0d",
                 rowName, q, int'(rowWindow) + 1, runLen);
        errors++;
        rowErrors++;
      end
      if (runLen > maxRun)
        maxRun = runLen;
      lastPort = q;
      expFlit = expQ[q].pop_front();
      pending--;
      if (outFlit !== expFlit)
      begin
        $display("Error %s: flit on port %0d expected %h actual %h",
                 rowName, q, expFlit, outFlit);
        errors++;
        rowErrors++;
      end
    end
  endtask

  task automatic finishRow();
    if (maxRun != int'(rowMaxRun))
    begin
      $display("Error %s: longest run expected %0d actual %0d", rowName, rowMaxRun, maxRun);
      errors++;
      rowErrors++;
    end
    if (rowErrors == 0)
      $display("%s: ok, %0d flits, longest run %0d", rowName, rowFlits, maxRun);
    else
      $display("%s: %0d errors", rowName, rowErrors);
  endtask

  always @(posedge clk)
  begin
    if (rst)
    begin
      if (outValid === 1'b1)
      begin
        $display("outValid went high while reset was asserted");
        errors++;
      end
    end
    else
    begin
      if (rowStart)
      begin
        lastPort = -1;
        runLen = 0;
        maxRun = 0;
        rowErrors = 0;
        rowFlits = 0;
      end
      if (outValid)
        checkDelivery();
      for (int p = 0; p < `ROUTER_PORTS; p++)
      begin
        if (inPush[p])
        begin
          expQ[p].push_back(inFlit[p]);
          pending++;
        end
      end
      if (rowEnd)
        finishRow();
    end
  end

endmodule

`default_nettype wire

//--- verification/routerTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "router_defs.svh"

module routerTb;
  import routerPkg::*;

  localparam int NumRows = 7;

  typedef struct packed {
    logic [127:0] name;
    portMask_t mask;
    logic [`ROUTER_PORTS-1:0][2:0] count;
    holdLen_t window;
    logic [7:0] maxRun;
  } rowCfg_t;

  rowCfg_t rows [NumRows];
  logic clk;
  logic rst;
  portMask_t inPush;
  flit_t [`ROUTER_PORTS-1:0] inFlit;
  logic outValid;
  flit_t outFlit;
  portIdx_t outPort;
  logic [127:0] rowName;
  holdLen_t rowWindow;
  logic [7:0] rowMaxRun;
  logic rowStart;
  logic rowEnd;
  int errors;
  int flitCount;
  logic drained;
  logic [31:0] rngState;
  int limitCycles = 0;

  routerOutputStage uut (
    .clk      (clk),
    .rst      (rst),
    .inPush   (inPush),
    .inFlit   (inFlit),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

  routerChecker uChecker (
    .clk       (clk),
    .rst       (rst),
    .inPush    (inPush),
    .inFlit    (inFlit),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .outPort   (outPort),
    .rowName   (rowName),
    .rowWindow (rowWindow),
    .rowMaxRun (rowMaxRun),
    .rowStart  (rowStart),
    .rowEnd    (rowEnd),
    .errors    (errors),
    .flitCount (flitCount),
    .drained   (drained)
  );

  always #5 clk = ~clk;

  function automatic rowCfg_t makeRow(logic [127:0] name, portMask_t mask, int cL, int cN,
                                      int cE, int cW, int cS, int window, int maxRun);
    rowCfg_t r;
    r.name = name;
    r.mask = mask;
    r.count[`PORT_L] = 3'(cL);
    r.count[`PORT_N] = 3'(cN);
    r.count[`PORT_E] = 3'(cE);
    r.count[`PORT_W] = 3'(cW);
    r.count[`PORT_S] = 3'(cS);
    r.window = holdLen_t'(window);
    r.maxRun = 8'(maxRun);
    return r;
  endfunction

  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // A packet opens with a head flit that carries the window.
  // Body flits use id 2 and the tail uses id 3.
  function automatic flit_t makeFlit(int beat, int last, holdLen_t window);
    flit_t f;
    logic [31:0] rnd;
    rnd = nextRandom();
    if (beat == 0)
    begin
      f.id = flitId_t'(`FLIT_HEAD);
      f.data = {rnd[15:12], window};
    end
    else
    begin
      f.id = (beat == last) ? 3'd3 : 3'd2;
      f.data = rnd[15:0];
    end
    return f;
  endfunction

  task automatic driveRow(rowCfg_t row);
    int beats;
    beats = 0;
    for (int p = 0; p < `ROUTER_PORTS; p++)
      if (row.mask[p] && int'(row.count[p]) > beats)
        beats = int'(row.count[p]);
    for (int b = 0; b < beats; b++)
    begin
      for (int p = 0; p < `ROUTER_PORTS; p++)
      begin
        if (row.mask[p] && b < int'(row.count[p]))
        begin
          inPush[p] = 1'b1;
          inFlit[p] = makeFlit(b, int'(row.count[p]) - 1, row.window);
        end
        else
          inPush[p] = 1'b0;
      end
      @(negedge clk);
    end
    inPush = '0;
  endtask

  initial
  begin
    int totalFlits;
    // The longest run is the packet length for a port on its own and window plus one
    // under contention.
    rows[0] = makeRow("reset idle", 5'b00000, 0, 0, 0, 0, 0, 0, 0);
    rows[1] = makeRow("single local", 5'b00001, 4, 0, 0, 0, 0, 0, 4);
    rows[2] = makeRow("single south", 5'b10000, 0, 0, 0, 0, 3, 2, 3);
    rows[3] = makeRow("all ports w2", 5'b11111, 4, 4, 4, 4, 4, 2, 3);
    rows[4] = makeRow("all ports w0", 5'b11111, 4, 4, 4, 4, 4, 0, 1);
    rows[5] = makeRow("south wrap", 5'b10001, 2, 0, 0, 0, 2, 0, 1);
    rows[6] = makeRow("mixed w2", 5'b10111, 1, 4, 2, 0, 4, 2, 3);
    totalFlits = 0;
    for (int r = 0; r < NumRows; r++)
      for (int p = 0; p < `ROUTER_PORTS; p++)
        totalFlits += int'(rows[r].count[p]);
    clk = 1'b0;
    rst = 1'b1;
    inPush = '0;
    inFlit = '0;
    rowName = '0;
    rowWindow = '0;
    rowMaxRun = '0;
    rowStart = 1'b0;
    rowEnd = 1'b0;
    rngState = 32'd22712;
    limitCycles = 40 * totalFlits + 10;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < NumRows; r++)
    begin
      rowName = rows[r].name;
      rowWindow = rows[r].window;
      rowMaxRun = rows[r].maxRun;
      rowStart = 1'b1;
      @(negedge clk);
      rowStart = 1'b0;
      driveRow(rows[r]);
      while (!drained)
        @(negedge clk);
      // Idle cycles after the last flit expose a duplicate delivery.
      repeat (5) @(negedge clk);
      rowEnd = 1'b1;
      @(negedge clk);
      rowEnd = 1'b0;
    end
    $display("Rows %0d, flits checked %0d, errors %0d", NumRows, flitCount, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    wait (limitCycles != 0);
    repeat (limitCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limitCycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+rtl
rtl/routerPkg.sv
rtl/flitFifo.sv
rtl/holdTimer.sv
rtl/portArbiter.sv
rtl/outputSwitch.sv
rtl/routerOutputStage.sv
verification/routerChecker.sv
verification/routerTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module routerTb -o routerSim
./obj_dir/routerSim | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
  echo "Simulation passed, see sim.log"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
